// ==== src.f ====
logic/dbg_io_pkg.sv
logic/dbg_scratch_regs.sv
logic/dbg_halt_ctrl.sv
logic/dbg_print_fifo.sv
logic/dbg_bus_decode.sv
logic/dbg_io_top.sv
sim/dbg_io_checker.sv
sim/tb_dbg_io.sv

// ==== Bender.yml ====
package:
  name: dbg_io

sources:
  - logic/dbg_io_pkg.sv
  - logic/dbg_scratch_regs.sv
  - logic/dbg_halt_ctrl.sv
  - logic/dbg_print_fifo.sv
  - logic/dbg_bus_decode.sv
  - logic/dbg_io_top.sv
  - target: simulation
    files:
      - sim/dbg_io_checker.sv
      - sim/tb_dbg_io.sv

// ==== sim/tb_dbg_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_io;
   import dbg_io_pkg::*;

   localparam int fifo_depth    = 8;
   localparam int scratch_depth = 16;

   typedef struct packed {
      logic     rst;                          // Reset pulse, no bus access.
      logic     we;
      logic     hold;                         // Keep the drain ready low.
      io_addr_t adr;
      io_data_t dat;
      io_data_t exp;                          // Read data, unused on writes.
   } entry_t;

   logic       nw;
   logic       rst_n;
   wb_req_t    bus_req;
   wb_rsp_t    bus_rsp;
   logic       print_valid;
   print_rec_t print_rec;
   logic       print_ready;
   logic       halt;
   logic       assert_fail;
   logic       hold_ready;
   int         errors;
   int         n_entries = 0;
   entry_t     tbl [$];
   string      names [$];

   dbg_io_top #(
      .fifo_depth    (fifo_depth),
      .scratch_depth (scratch_depth)
   ) dut_i (
      .nw          (nw),
      .rst_n       (rst_n),
      .bus_req     (bus_req),
      .bus_rsp     (bus_rsp),
      .print_valid (print_valid),
      .print_rec   (print_rec),
      .print_ready (print_ready),
      .halt        (halt),
      .assert_fail (assert_fail)
   );

   dbg_io_checker #(
      .fifo_depth    (fifo_depth),
      .scratch_depth (scratch_depth)
   ) chk_i (
      .nw          (nw),
      .rst_n       (rst_n),
      .bus_req     (bus_req),
      .bus_rsp     (bus_rsp),
      .print_valid (print_valid),
      .print_rec   (print_rec),
      .print_ready (print_ready),
      .halt        (halt),
      .assert_fail (assert_fail),
      .errors      (errors)
   );

   initial begin
      nw = 1'b0;
      forever #4 nw = ~nw;                    // 8 ns period.
   end

   // Host drain, mostly not ready so bursts back up.
   initial begin
      print_ready = 1'b0;
      void'($urandom(77));                    // One seed for the whole run.
      forever begin
         @(posedge nw);
         #1;
         print_ready = hold_ready ? 1'b0 : ($urandom % 3 == 0);
      end
   end

   ////////////////////////////////
   // Stimulus helpers.
   ////////////////////////////////

   task automatic add(input logic rst, input logic we, input logic hold, input io_addr_t adr,
                      input io_data_t dat, input io_data_t exp, input string name);
      tbl.push_back('{rst, we, hold, adr, dat, exp});
      names.push_back(name);
   endtask

   task automatic pulse_reset();
      @(posedge nw);
      #1;
      rst_n = 1'b0;
      repeat (4) @(posedge nw);
      #1;
      rst_n = 1'b1;
   endtask

   task automatic run_access(input entry_t e);
      int waited;
      waited     = 0;
      hold_ready = e.hold;
      @(posedge nw);
      #1;
      bus_req = '{cyc: 1'b1, stb: 1'b1, we: e.we, adr: e.adr, dat: e.dat};
      @(negedge nw);
      while (!bus_rsp.ack) begin
         waited++;
         if (waited == 20) hold_ready = 1'b0;  // Let a stalled burst drain.
         @(negedge nw);
      end
      @(posedge nw);
      #1;
      bus_req = '0;                           // Master drops stb after ack.
   endtask

   task automatic drain_fifo();
      hold_ready = 1'b0;
      do @(negedge nw); while (print_valid);
      #1;                                     // Checker is done with this edge.
   endtask

   task automatic build_table();
      for (int i = 0; i < scratch_depth; i++) begin
         add(0, 0, 0, 10'h040 + 10'(i), 0, 0, "scratch_zero");
      end
      add(0, 1, 0, 10'h001, 16'h1234, 0, "scratch_rw");
      add(0, 1, 0, 10'h2a7, 16'ha5a5, 0, "scratch_rw");
      add(0, 1, 0, 10'h3fc, 16'h0c0c, 0, "scratch_rw");        // Status is read only.
      add(0, 0, 0, 10'h101, 0, 16'h1234, "scratch_rw");
      add(0, 0, 0, 10'h007, 0, 16'ha5a5, "scratch_rw");
      add(0, 0, 0, 10'h1fc, 0, 16'h0c0c, "scratch_rw");
      for (int i = 0; i < 8; i++) begin
         add(0, 1, 0, 10'h3f0 + 10'(i), 16'h0100 + 16'(i), 0, "print_each");
      end
      for (int i = 0; i < 12; i++) add(0, 1, 1, 10'h3f4, 16'hbe00 + 16'(i), 0, "print_stall");
      for (int i = 0; i < 3; i++) add(0, 1, 0, 10'h3fe, 0, 0, "assert_pass");
      add(0, 0, 0, 10'h3fd, 0, 16'h0003, "assert_pass");
      add(0, 1, 1, 10'h3f2, 16'h0007, 0, "assert_fail");       // One record left queued.
      add(0, 1, 1, 10'h3ff, 0, 0, "assert_fail");
      add(0, 0, 1, 10'h3fc, 0, 16'hc001, "assert_fail");
      add(0, 0, 1, 10'h3fd, 0, 16'h0003, "assert_fail");
      add(0, 1, 0, 10'h005, 16'h0055, 0, "assert_fail");
      add(0, 0, 0, 10'h005, 0, 16'h0055, "assert_fail");
      add(1, 0, 0, 10'h000, 0, 0, "reset");
      add(0, 1, 0, 10'h00f, 0, 0, "halt_only");
      add(0, 0, 0, 10'h3fc, 0, 16'h8000, "halt_only");
      add(0, 0, 0, 10'h3fd, 0, 16'h0000, "halt_only");
      add(0, 1, 0, 10'h3f1, 16'h0041, 0, "halt_only");
      add(0, 0, 0, 10'h005, 0, 16'h0000, "halt_only");
   endtask

   ////////////////////////////////
   // Main sequence and watchdog.
   ////////////////////////////////

   initial begin
      rst_n      = 1'b0;
      bus_req    = '0;
      hold_ready = 1'b0;
      build_table();
      n_entries = tbl.size();
      repeat (4) @(posedge nw);
      #1;
      rst_n = 1'b1;
      for (int i = 0; i < tbl.size(); i++) begin
         if (i > 0 && names[i] != names[i-1]) begin
            drain_fifo();                     // Each test starts with an empty FIFO.
            chk_i.end_test(names[i-1]);
         end
         if (tbl[i].rst) begin
            pulse_reset();
         end else begin
            chk_i.set_expect(tbl[i].exp);
            run_access(tbl[i]);
         end
      end
      drain_fifo();
      chk_i.end_test(names[names.size()-1]);
      chk_i.report();
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial begin
      wait (n_entries > 0);
      repeat (n_entries * 200) @(posedge nw);
      $display("timeout: the run did not finish within %0d cycles", n_entries * 200);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/dbg_io_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbg_io_checker #(
   parameter int fifo_depth    = 8,
   parameter int scratch_depth = 16
) (
   input  logic                    nw,
   input  logic                    rst_n,
   input  dbg_io_pkg::wb_req_t     bus_req,
   input  dbg_io_pkg::wb_rsp_t     bus_rsp,
   input  logic                    print_valid,
   input  dbg_io_pkg::print_rec_t  print_rec,
   input  logic                    print_ready,
   input  logic                    halt,
   input  logic                    assert_fail,
   output int                      errors
);
   import dbg_io_pkg::*;

   print_rec_t q [$];                         // Records the host has not taken yet.
   io_data_t   scr_m [scratch_depth];
   io_data_t   exp_tbl;                       // Read data from the table entry.
   count_t     pass_m;
   logic       halt_m;
   logic       fail_m;
   logic       pop_pend;                      // Host takes the head on the next edge.
   logic       due;                           // Ack must show at the next sample.
   int         prev_size;                     // Level seen by the last read capture.
   int         checks;
   int         test_errs;
   int         tests;
   int         tests_failed;

   initial begin
      errors       = 0;
      checks       = 0;
      test_errs    = 0;
      tests        = 0;
      tests_failed = 0;
   end

   ////////////////////////////////
   // Reporting.
   ////////////////////////////////

   task automatic check_val(input string sig, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         test_errs++;
         $display("error at %0t: %s expected %h, actual %h", $time, sig, exp, act);
      end
   endtask

   task automatic fail_plain(input string what);
      errors++;
      test_errs++;
      $display("at %0t the bus %s", $time, what);
   endtask

   task automatic set_expect(input io_data_t exp);
      exp_tbl = exp;
   endtask

   task automatic end_test(input string name);
      tests++;
      if (test_errs == 0) begin
         $display("test %-13s passed", name);
      end else begin
         tests_failed++;
         $display("test %-13s failed with %0d errors", name, test_errs);
      end
      test_errs = 0;
   endtask

   task automatic report();
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests, tests_failed, checks, errors);
   endtask

   ////////////////////////////////
   // Model of one acked access.
   ////////////////////////////////

   task automatic take_access();
      io_addr_t   a;
      io_data_t   rd;
      print_rec_t rec;
      a = bus_req.adr;
      if (bus_req.we) begin
         if (a == addr_halt) begin
            halt_m = 1'b1;
         end else if (a[9:3] == addr_print_base[9:3]) begin
            rec.kind = print_kind_e'(a[2:0]);        // Offset from 0x3f0.
            case (rec.kind)
               print_addr:    rec.value = io_data_t'(a);
               print_space:   rec.value = 16'd32;
               print_newline: rec.value = 16'd10;
               default:       rec.value = bus_req.dat;
            endcase
            q.push_back(rec);
         end else if (a == addr_assert_ok) begin
            pass_m++;                                // Wraps at 16 bits.
         end else if (a == addr_assert_fail) begin
            halt_m = 1'b1;
            fail_m = 1'b1;
         end else begin
            scr_m[a % scratch_depth] = bus_req.dat;  // Low bits alias.
         end
      end else begin
         if (a == addr_status) begin
            rd     = 16'(prev_size);
            rd[15] = halt_m;
            rd[14] = fail_m;
         end else if (a == addr_pass_cnt) begin
            rd = pass_m;
         end else begin
            rd = scr_m[a % scratch_depth];
         end
         check_val("bus_rsp.dat", rd, bus_rsp.dat);
         check_val("bus_rsp.dat (table)", exp_tbl, bus_rsp.dat);
      end
   endtask

   // Outputs are sampled mid cycle, inputs change just after the rising edge.
   always @(negedge nw) begin
      if (!rst_n) begin
         q.delete();
         for (int i = 0; i < scratch_depth; i++) begin
            scr_m[i] = '0;
         end
         halt_m    = 1'b0;
         fail_m    = 1'b0;
         pass_m    = '0;
         pop_pend  = 1'b0;
         due       = 1'b0;
         prev_size = 0;
      end else begin
         if (pop_pend) begin
            void'(q.pop_front());
         end
         if (bus_rsp.ack && !due) fail_plain("acked with no request ready or with the FIFO full");
         if (!bus_rsp.ack && due) fail_plain("did not ack a request one cycle after it was ready");
         if (bus_rsp.ack) begin
            take_access();
         end
         check_val("halt", halt_m, halt);
         check_val("assert_fail", fail_m, assert_fail);
         check_val("print_valid", q.size() != 0, print_valid);
         if (print_valid && q.size() != 0) begin
            check_val("print_rec", q[0], print_rec);
         end
         pop_pend  = print_valid && print_ready;
         due       = bus_req.cyc && bus_req.stb && !bus_rsp.ack &&
                     !(bus_req.we && bus_req.adr[9:3] == addr_print_base[9:3] &&
                       q.size() >= fifo_depth);       // Stalled while full.
         prev_size = q.size();
      end
   end

endmodule

`default_nettype wire

// ==== logic/dbg_io_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbg_io_top #(
   parameter int fifo_depth    = 8,
   parameter int scratch_depth = 16
) (
   input  logic                    nw,
   input  logic                    rst_n,
   input  dbg_io_pkg::wb_req_t     bus_req,
   output dbg_io_pkg::wb_rsp_t     bus_rsp,
   output logic                    print_valid,
   output dbg_io_pkg::print_rec_t  print_rec,
   input  logic                    print_ready,
   output logic                    halt,
   output logic                    assert_fail
);
   import dbg_io_pkg::*;

   localparam int lvl_w = $clog2(fifo_depth) + 1;
   localparam int idx_w = $clog2(scratch_depth);

   logic              push;                   // One record per print write.
   print_rec_t        push_rec;
   logic              fifo_full;
   logic [lvl_w-1:0]  fifo_level;
   logic              halt_req;
   logic              ok_stb;
   logic              fail_stb;
   count_t            pass_cnt;
   logic              scr_we;
   logic [idx_w-1:0]  scr_idx;
   io_data_t          scr_wdata;
   io_data_t          scr_rdata;

   //////////////////////////////
   // Bus slave.
   //////////////////////////////

   dbg_bus_decode #(
      .fifo_depth    (fifo_depth),
      .scratch_depth (scratch_depth)
   ) decode_i (
      .nw          (nw),
      .rst_n       (rst_n),
      .bus_req     (bus_req),
      .bus_rsp     (bus_rsp),
      .push        (push),
      .push_rec    (push_rec),
      .fifo_full   (fifo_full),
      .fifo_level  (fifo_level),
      .halt_req    (halt_req),
      .assert_ok   (ok_stb),
      .assert_fail (fail_stb),
      .halted      (halt),
      .failed      (assert_fail),
      .pass_cnt    (pass_cnt),
      .scr_we      (scr_we),
      .scr_idx     (scr_idx),
      .scr_wdata   (scr_wdata),
      .scr_rdata   (scr_rdata)
   );

   //////////////////////////////
   // Print queue to the host.
   //////////////////////////////

   dbg_print_fifo #(
      .fifo_depth (fifo_depth)
   ) fifo_i (
      .nw        (nw),
      .rst_n     (rst_n),
      .push      (push),
      .push_rec  (push_rec),
      .full      (fifo_full),
      .level     (fifo_level),
      .out_valid (print_valid),
      .out_rec   (print_rec),
      .out_ready (print_ready)
   );

   dbg_halt_ctrl halt_i (
      .nw          (nw),
      .rst_n       (rst_n),
      .halt_req    (halt_req),
      .assert_ok   (ok_stb),
      .assert_fail (fail_stb),
      .halt        (halt),                    // Also fed back to status.
      .failed      (assert_fail),
      .pass_cnt    (pass_cnt)
   );

   dbg_scratch_regs #(
      .scratch_depth (scratch_depth)
   ) scratch_i (
      .nw    (nw),
      .rst_n (rst_n),
      .we    (scr_we),
      .idx   (scr_idx),
      .wdata (scr_wdata),
      .rdata (scr_rdata)
   );

endmodule

`default_nettype wire

// ==== logic/dbg_bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbg_bus_decode #(
   parameter int fifo_depth    = 8,
   parameter int scratch_depth = 16
) (
   input  logic                               nw,
   input  logic                               rst_n,
   input  dbg_io_pkg::wb_req_t                bus_req,
   output dbg_io_pkg::wb_rsp_t                bus_rsp,
   output logic                               push,
   output dbg_io_pkg::print_rec_t             push_rec,
   input  logic                               fifo_full,
   input  logic [$clog2(fifo_depth):0]        fifo_level,
   output logic                               halt_req,
   output logic                               assert_ok,
   output logic                               assert_fail,
   input  logic                               halted,
   input  logic                               failed,
   input  dbg_io_pkg::count_t                 pass_cnt,
   output logic                               scr_we,
   output logic [$clog2(scratch_depth)-1:0]   scr_idx,
   output dbg_io_pkg::io_data_t               scr_wdata,
   input  dbg_io_pkg::io_data_t               scr_rdata
);
   import dbg_io_pkg::*;

   localparam int lvl_w = $clog2(fifo_depth) + 1;
   localparam int idx_w = $clog2(scratch_depth);

   typedef enum logic [2:0] {
      cls_halt, cls_print, cls_ok, cls_fail, cls_status, cls_pass, cls_scratch
   } acc_class_e;

   acc_class_e  acc_class;
   print_kind_e rec_kind;
   logic        req_valid;
   logic        stall;
   logic        accept;
   logic        wr_acc;
   logic        ack_q;
   io_data_t    status_word;
   io_data_t    rd_mux;
   io_data_t    rdat_q;

   //////////////////////////////
   // Address decode.
   //////////////////////////////

   always_comb begin
      if (bus_req.adr == addr_halt) begin
         acc_class = cls_halt;
      end else if (bus_req.adr[9:3] == addr_print_base[9:3]) begin
         acc_class = cls_print;                // Eight print slots.
      end else if (bus_req.adr == addr_assert_ok) begin
         acc_class = cls_ok;
      end else if (bus_req.adr == addr_assert_fail) begin
         acc_class = cls_fail;
      end else if (bus_req.adr == addr_status) begin
         acc_class = cls_status;
      end else if (bus_req.adr == addr_pass_cnt) begin
         acc_class = cls_pass;
      end else begin
         acc_class = cls_scratch;              // Everything else aliases here.
      end
   end

   // No new request while ack is out, the master is still holding stb.
   assign req_valid = bus_req.cyc && bus_req.stb && !ack_q;
   assign stall     = bus_req.we && (acc_class == cls_print) && fifo_full;
   assign accept    = req_valid && !stall;
   assign wr_acc    = accept && bus_req.we;

   // Strobes are taken by the blocks on the same edge as ack.
   assign push        = wr_acc && (acc_class == cls_print);
   assign halt_req    = wr_acc && (acc_class == cls_halt);
   assign assert_ok   = wr_acc && (acc_class == cls_ok);
   assign assert_fail = wr_acc && (acc_class == cls_fail);
   // Status and pass count are read-only, writes there land in scratch.
   assign scr_we    = wr_acc && (acc_class inside {cls_scratch, cls_status, cls_pass});
   assign scr_idx   = bus_req.adr[idx_w-1:0];  // Low bits only.
   assign scr_wdata = bus_req.dat;

   always_comb begin
      rec_kind       = print_kind_e'(bus_req.adr[2:0]);
      push_rec.kind  = rec_kind;
      case (rec_kind)
         print_addr:    push_rec.value = io_data_t'(bus_req.adr);
         print_space:   push_rec.value = 16'd32;
         print_newline: push_rec.value = 16'd10;
         default:       push_rec.value = bus_req.dat;
      endcase
   end

   //////////////////////////////
   // Read path and ack.
   //////////////////////////////

   always_comb begin
      status_word              = '0;
      status_word[15]          = halted;
      status_word[14]          = failed;
      status_word[lvl_w-1:0]   = fifo_level; // Records waiting.
   end

   always_comb begin
      case (acc_class)
         cls_status: rd_mux = status_word;
         cls_pass:   rd_mux = pass_cnt;
         default:    rd_mux = scr_rdata;
      endcase
   end

   always_ff @(posedge nw) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= accept;                      // Single-cycle ack.
      end
   end

   always_ff @(posedge nw) begin
      if (accept && !bus_req.we) begin
         rdat_q <= rd_mux;                     // Valid in the ack cycle.
      end
   end

   assign bus_rsp = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

// ==== logic/dbg_print_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbg_print_fifo #(
   parameter int fifo_depth = 8
) (
   input  logic                          nw,
   input  logic                          rst_n,
   input  logic                          push,
   input  dbg_io_pkg::print_rec_t        push_rec,
   output logic                          full,
   output logic [$clog2(fifo_depth):0]   level,
   output logic                          out_valid,
   output dbg_io_pkg::print_rec_t        out_rec,
   input  logic                          out_ready
);
   import dbg_io_pkg::*;

   localparam int aw = $clog2(fifo_depth);

   print_rec_t  mem [fifo_depth];             // Record storage.
   logic [aw-1:0] wr_ptr;
   logic [aw-1:0] rd_ptr;
   logic [aw:0]   count;
   logic          do_push;
   logic          do_pop;

   assign full      = (count == (aw + 1)'(fifo_depth));
   assign level     = count;
   assign out_valid = (count != '0);          // Head is shown as soon as it exists.
   assign out_rec   = mem[rd_ptr];

   assign do_push = push && !full;            // Decoder already stalls on full.
   assign do_pop  = out_valid && out_ready;

   //////////////////////////////
   // Storage.
   //////////////////////////////

   always_ff @(posedge nw) begin
      if (do_push) begin
         mem[wr_ptr] <= push_rec;
      end
   end

   //////////////////////////////
   // Pointers and occupancy.
   //////////////////////////////

   always_ff @(posedge nw) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;           // Wraps, depth is a power of two.
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;           // Both or neither.
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/dbg_halt_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbg_halt_ctrl (
   input  logic                nw,
   input  logic                rst_n,
   input  logic                halt_req,
   input  logic                assert_ok,
   input  logic                assert_fail,
   output logic                halt,
   output logic                failed,
   output dbg_io_pkg::count_t  pass_cnt
);
   import dbg_io_pkg::*;

   logic   halt_q;
   logic   failed_q;
   count_t cnt_q;

   //////////////////////////////
   // Sticky flags.
   //////////////////////////////

   always_ff @(posedge nw) begin
      if (!rst_n) begin
         halt_q   <= 1'b0;
         failed_q <= 1'b0;
      end else begin
         if (halt_req || assert_fail) begin
            halt_q <= 1'b1;                    // A failed assertion also stops.
         end
         if (assert_fail) begin
            failed_q <= 1'b1;
         end
      end
   end

   // Pass counter, wraps at 16 bits.
   always_ff @(posedge nw) begin
      if (!rst_n) begin
         cnt_q <= '0;
      end else if (assert_ok) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   assign halt     = halt_q;
   assign failed   = failed_q;
   assign pass_cnt = cnt_q;

endmodule

`default_nettype wire

// ==== logic/dbg_scratch_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbg_scratch_regs #(
   parameter int scratch_depth = 16
) (
   input  logic                               nw,
   input  logic                               rst_n,
   input  logic                               we,
   input  logic [$clog2(scratch_depth)-1:0]   idx,
   input  dbg_io_pkg::io_data_t               wdata,
   output dbg_io_pkg::io_data_t               rdata
);
   import dbg_io_pkg::*;

   io_data_t regs [scratch_depth];            // Scratch words.

   //////////////////////////////
   // Write port.
   //////////////////////////////

   always_ff @(posedge nw) begin
      if (!rst_n) begin
         for (int i = 0; i < scratch_depth; i++) begin
            regs[i] <= '0;                     // Reads back zero after reset.
         end
      end else if (we) begin
         regs[idx] <= wdata;
      end
   end

   // Read is combinational, same index as the write.
   assign rdata = regs[idx];

endmodule

`default_nettype wire

// ==== logic/dbg_io_pkg.sv ====
`default_nettype none

package dbg_io_pkg;

   ////////////////////////////////
   // Widths.
   ////////////////////////////////

   typedef logic [9:0]  io_addr_t;             // I/O window address.
   typedef logic [15:0] io_data_t;             // Bus data word.
   typedef logic [15:0] count_t;               // Assertion pass counter.

   // Print kinds, in address order from 0x3f0.
   typedef enum logic [2:0] {
      print_addr    = 3'd0,                    // Address of the write.
      print_char    = 3'd1,                    // Character code.
      print_sdec    = 3'd2,                    // Signed decimal.
      print_udec    = 3'd3,                    // Unsigned decimal.
      print_hex     = 3'd4,                    // Hexadecimal.
      print_bin     = 3'd5,                    // Binary.
      print_space   = 3'd6,                    // Fixed blank.
      print_newline = 3'd7                     // Fixed line feed.
   } print_kind_e;

   typedef struct packed {
      print_kind_e kind;                       // How the host shows it.
      io_data_t    value;                      // Payload.
   } print_rec_t;

   ////////////////////////////////
   // Wishbone classic.
   ////////////////////////////////

   typedef struct packed {
      logic     cyc;                           // Bus cycle in progress.
      logic     stb;                           // Transfer request.
      logic     we;                            // Write when high.
      io_addr_t adr;
      io_data_t dat;                           // Write data.
   } wb_req_t;

   typedef struct packed {
      logic     ack;                           // One cycle per transfer.
      io_data_t dat;                           // Read data.
   } wb_rsp_t;

   // Fixed locations in the window.
   localparam io_addr_t addr_halt        = 10'h00f;
   localparam io_addr_t addr_print_base  = 10'h3f0;
   localparam io_addr_t addr_status      = 10'h3fc;
   localparam io_addr_t addr_pass_cnt    = 10'h3fd;
   localparam io_addr_t addr_assert_ok   = 10'h3fe;
   localparam io_addr_t addr_assert_fail = 10'h3ff;

endpackage

`default_nettype wire
